// File: hw/mem_rob_config.svh
// Size definitions for the memory reorder bridge, included by the packages and the RTL modules
`ifndef MEM_ROB_CONFIG_SVH
`define MEM_ROB_CONFIG_SVH

// Master address width in words, not bytes
`define MEM_ROB_ADDR_WIDTH 8

// Data word width
`define MEM_ROB_DATA_WIDTH 32

// Width of the user value the master attaches to every request
`define MEM_ROB_USER_WIDTH 4

// Reorder index width, which also sets the depth of each reorder buffer
`define MEM_ROB_TAG_WIDTH 3

// Entries per reorder buffer, one for every tag value
`define MEM_ROB_ENTRIES (1 << `MEM_ROB_TAG_WIDTH)

// Words actually backed by storage in the memory model
`define MEM_ROB_MEM_WORDS 128

// Commands the memory model can hold in flight at once
`define MEM_ROB_SLOTS 4

`endif

// File: hw/mem_bus_pkg.sv
// Master-side request and response types of the memory port, shared by the bridge and the bench
`include "mem_rob_config.svh"

package mem_bus_pkg;

    // Basic field widths of the master port
    localparam int ADDR_WIDTH = `MEM_ROB_ADDR_WIDTH;
    localparam int DATA_WIDTH = `MEM_ROB_DATA_WIDTH;
    localparam int USER_WIDTH = `MEM_ROB_USER_WIDTH;

    // One byte enable per data byte
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;
    typedef logic [USER_WIDTH-1:0] user_t;
    typedef logic [1:0]            resp_t;

    // Avalon response codes that the memory can return
    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // Request from the master, held as levels until waitrequest drops
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        data_t writedata;
        be_t   byteenable;
        user_t user;
    } mem_req_t;

    // Read response back to the master, valid for a single cycle
    typedef struct packed {
        logic  valid;
        data_t readdata;
        resp_t response;
        user_t user;
    } mem_rd_rsp_t;

    // Write response back to the master, also a single-cycle pulse
    typedef struct packed {
        logic  valid;
        resp_t response;
        user_t user;
    } mem_wr_rsp_t;

endpackage

// File: hw/rob_pkg.sv
// Slave-side tagged command and response types and the reorder payloads used inside the bridge
`include "mem_rob_config.svh"

package rob_pkg;

    // Reorder index carried by every command to the slave and back
    typedef logic [`MEM_ROB_TAG_WIDTH-1:0] rob_tag_t;

    // Command toward the memory slave, tagged with its reorder index
    typedef struct packed {
        logic               read;
        logic               write;
        mem_bus_pkg::addr_t address;
        mem_bus_pkg::data_t writedata;
        mem_bus_pkg::be_t   byteenable;
        rob_tag_t           tag;
    } slv_cmd_t;

    // Read completion from the slave, possibly out of order
    typedef struct packed {
        logic               valid;
        mem_bus_pkg::data_t readdata;
        mem_bus_pkg::resp_t response;
        rob_tag_t           tag;
    } slv_rd_rsp_t;

    // Write completion from the slave
    typedef struct packed {
        logic               valid;
        mem_bus_pkg::resp_t response;
        rob_tag_t           tag;
    } slv_wr_rsp_t;

    // What the read buffer stores per entry
    typedef struct packed {
        mem_bus_pkg::data_t readdata;
        mem_bus_pkg::resp_t response;
    } rd_payload_t;

    // The write buffer only needs the response code
    typedef struct packed {
        mem_bus_pkg::resp_t response;
    } wr_payload_t;

endpackage

// File: hw/rob_buffer.sv
// Reorder buffer that hands out in-order indices and releases out-of-order results in that order
`timescale 1ns/100ps
`include "mem_rob_config.svh"

module rob_buffer #(
    parameter type T_PAYLOAD = logic
) (
    input  logic                mem_master,
    input  logic                rst,
    input  logic                alloc_en,
    input  mem_bus_pkg::user_t  alloc_meta,
    output logic                not_full,
    output rob_pkg::rob_tag_t   alloc_idx,
    input  logic                enq_en,
    input  rob_pkg::rob_tag_t   enq_idx,
    input  T_PAYLOAD            enq_data,
    output logic                out_valid,
    output T_PAYLOAD            out_data,
    output mem_bus_pkg::user_t  out_meta
);

    localparam int ENTRIES = `MEM_ROB_ENTRIES;
    localparam int CNT_W   = `MEM_ROB_TAG_WIDTH + 1;

    // Payload and metadata arrays indexed by the reorder index
    T_PAYLOAD           data_mem [ENTRIES];
    mem_bus_pkg::user_t meta_mem [ENTRIES];

    // Set when the slave has delivered the result for an entry
    logic [ENTRIES-1:0] done;

    rob_pkg::rob_tag_t  alloc_ptr;
    rob_pkg::rob_tag_t  head_ptr;
    logic [CNT_W-1:0]   count;

    logic               alloc_ok;
    logic               deq;

    // First output stage, the second stage is the output itself
    logic               s1_valid;
    T_PAYLOAD           s1_data;
    mem_bus_pkg::user_t s1_meta;

    assign not_full  = (count != CNT_W'(ENTRIES));
    assign alloc_idx = alloc_ptr;
    assign alloc_ok  = alloc_en && not_full;

    // The head leaves as soon as its result is present, one entry per cycle
    assign deq = done[head_ptr];

    // ==========================================================
    // Pointers, occupancy and completion flags
    // ==========================================================
    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            alloc_ptr <= '0;
            head_ptr  <= '0;
            count     <= '0;
            done      <= '0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (alloc_ok)
                alloc_ptr <= alloc_ptr + 1'b1;
            if (deq)
                head_ptr <= head_ptr + 1'b1;

            // An entry stays counted until its response reaches the output
            count <= count + CNT_W'(alloc_ok) - CNT_W'(s1_valid);

            // A result never lands on the head that is leaving in the same cycle
            if (enq_en)
                done[enq_idx] <= 1'b1;
            if (deq)
                done[head_ptr] <= 1'b0;

            // Two register stages between head completion and the output pulse
            s1_valid  <= deq;
            out_valid <= s1_valid;
        end
    end

    // ==========================================================
    // Storage and output data path
    // ==========================================================
    always_ff @(posedge mem_master)
    begin
        if (alloc_ok)
            meta_mem[alloc_ptr] <= alloc_meta;
        if (enq_en)
            data_mem[enq_idx] <= enq_data;

        // The head advances on dequeue, so its contents move into the pipeline
        s1_data  <= data_mem[head_ptr];
        s1_meta  <= meta_mem[head_ptr];
        out_data <= s1_data;
        out_meta <= s1_meta;
    end

endmodule

// File: hw/cmd_fifo2.sv
// Two-entry command queue that carries tagged commands from the bridge to the memory slave
`timescale 1ns/100ps

module cmd_fifo2 (
    input  logic              mem_master,
    input  logic              rst,
    input  logic              enq_en,
    input  rob_pkg::slv_cmd_t enq_data,
    output logic              not_full,
    output rob_pkg::slv_cmd_t first,
    output logic              not_empty,
    input  logic              deq_en
);

    // Entry zero is always the head, entry one sits behind it
    rob_pkg::slv_cmd_t q0;
    rob_pkg::slv_cmd_t q1;
    logic              v0;
    logic              v1;

    logic              do_deq;
    logic              do_enq;

    assign not_full  = !v1;
    assign not_empty = v0;
    assign first     = q0;

    // A full queue still takes a write when the head leaves in the same cycle
    assign do_deq = deq_en && v0;
    assign do_enq = enq_en && (!v1 || do_deq);

    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            v0 <= 1'b0;
            v1 <= 1'b0;
        end
        else
        begin
            case ({do_enq, do_deq})
                2'b10:
                begin
                    if (!v0)
                        v0 <= 1'b1;
                    else
                        v1 <= 1'b1;
                end
                2'b01:
                begin
                    v0 <= v1;
                    v1 <= 1'b0;
                end
                // Enqueue with dequeue keeps the occupancy unchanged
                default: ;
            endcase
        end
    end

    // Registered storage, so a written entry shows at the head one cycle later
    always_ff @(posedge mem_master)
    begin
        if (do_deq)
        begin
            q0 <= v1 ? q1 : enq_data;
            if (v1 && do_enq)
                q1 <= enq_data;
        end
        else if (do_enq)
        begin
            if (!v0)
                q0 <= enq_data;
            else
                q1 <= enq_data;
        end
    end

endmodule

// File: hw/ooo_mem_model.sv
// Memory slave model that completes tagged commands out of order after pseudo-random delays
`timescale 1ns/100ps
`include "mem_rob_config.svh"

module ooo_mem_model (
    input  logic                 mem_master,
    input  logic                 rst,
    input  rob_pkg::slv_cmd_t    cmd,
    output logic                 waitrequest,
    output rob_pkg::slv_rd_rsp_t rd_rsp,
    output rob_pkg::slv_wr_rsp_t wr_rsp
);

    localparam int SLOTS = `MEM_ROB_SLOTS;
    localparam int WORDS = `MEM_ROB_MEM_WORDS;
    localparam int IDX_W = $clog2(SLOTS);
    localparam int WRD_W = $clog2(WORDS);
    localparam int BE_W  = mem_bus_pkg::BE_WIDTH;

    // Everything a pending command needs to form its response
    typedef struct packed {
        logic               is_write;
        rob_pkg::rob_tag_t  tag;
        mem_bus_pkg::data_t data;
        mem_bus_pkg::resp_t resp;
    } slot_t;

    mem_bus_pkg::data_t mem [WORDS];

    slot_t              slot [SLOTS];
    logic [SLOTS-1:0]   slot_busy;
    logic [2:0]         slot_wait [SLOTS];

    logic [7:0]         lfsr;
    logic               accept;
    logic               in_range;
    logic [WRD_W-1:0]   word_idx;
    mem_bus_pkg::data_t cap_data;
    logic [IDX_W-1:0]   free_idx;
    logic [IDX_W-1:0]   ret_idx;
    logic               ret_valid;

    // Stall only while every slot holds a pending command
    assign waitrequest = &slot_busy;
    assign accept      = (cmd.read || cmd.write) && !waitrequest;

    assign in_range = (cmd.address < mem_bus_pkg::addr_t'(WORDS));
    assign word_idx = cmd.address[WRD_W-1:0];

    // Out of range reads return zero along with the error code
    assign cap_data = (in_range && cmd.read) ? mem[word_idx] : '0;

    // Pick the lowest free slot and the lowest slot whose countdown is over
    always_comb
    begin
        free_idx  = '0;
        ret_idx   = '0;
        ret_valid = 1'b0;
        for (int i = SLOTS - 1; i >= 0; i--)
        begin
            if (!slot_busy[i])
                free_idx = IDX_W'(i);
            if (slot_busy[i] && slot_wait[i] == 3'd0)
            begin
                ret_valid = 1'b1;
                ret_idx   = IDX_W'(i);
            end
        end
    end

    // ==========================================================
    // Word array, written in command order at acceptance
    // ==========================================================
    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            for (int w = 0; w < WORDS; w++)
                mem[w] <= '0;
        end
        else if (accept && cmd.write && in_range)
        begin
            for (int b = 0; b < BE_W; b++)
                if (cmd.byteenable[b])
                    mem[word_idx][8*b +: 8] <= cmd.writedata[8*b +: 8];
        end
    end

    // ==========================================================
    // Slot bookkeeping and delay generation
    // ==========================================================
    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            slot_busy <= '0;
            lfsr      <= 8'ha5;
        end
        else
        begin
            // Maximal length polynomial x^8 + x^6 + x^5 + x^4 + 1
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

            // Expired slots hold at zero until they win the response port
            for (int i = 0; i < SLOTS; i++)
                if (slot_busy[i] && slot_wait[i] != 3'd0)
                    slot_wait[i] <= slot_wait[i] - 3'd1;

            if (ret_valid)
                slot_busy[ret_idx] <= 1'b0;

            // A countdown of zero answers in the very next cycle
            if (accept)
            begin
                slot_busy[free_idx] <= 1'b1;
                slot_wait[free_idx] <= lfsr[2:0];
            end
        end
    end

    always_ff @(posedge mem_master)
    begin
        if (accept)
        begin
            slot[free_idx].is_write <= cmd.write;
            slot[free_idx].tag      <= cmd.tag;
            slot[free_idx].data     <= cap_data;
            slot[free_idx].resp     <= in_range ? mem_bus_pkg::resp_okay
                                                : mem_bus_pkg::resp_slverr;
        end
    end

    // One response per cycle, steered to the read or write channel
    assign rd_rsp = '{valid:    ret_valid && !slot[ret_idx].is_write,
                      readdata: slot[ret_idx].data,
                      response: slot[ret_idx].resp,
                      tag:      slot[ret_idx].tag};

    assign wr_rsp = '{valid:    ret_valid && slot[ret_idx].is_write,
                      response: slot[ret_idx].resp,
                      tag:      slot[ret_idx].tag};

endmodule

// File: hw/mem_rob_bridge.sv
// Reorder bridge that tags master commands and sorts slave responses back into request order
`timescale 1ns/100ps

module mem_rob_bridge (
    input  logic                     mem_master,
    input  logic                     rst,
    input  mem_bus_pkg::mem_req_t    req,
    output logic                     waitrequest,
    output mem_bus_pkg::mem_rd_rsp_t rd_rsp,
    output mem_bus_pkg::mem_wr_rsp_t wr_rsp,
    output rob_pkg::slv_cmd_t        slv_cmd,
    input  logic                     slv_waitrequest,
    input  rob_pkg::slv_rd_rsp_t     slv_rd_rsp,
    input  rob_pkg::slv_wr_rsp_t     slv_wr_rsp
);

    logic                 rd_not_full;
    logic                 wr_not_full;
    logic                 fifo_not_full;
    logic                 fifo_not_empty;
    logic                 rd_alloc;
    logic                 wr_alloc;
    rob_pkg::rob_tag_t    rd_alloc_idx;
    rob_pkg::rob_tag_t    wr_alloc_idx;
    rob_pkg::slv_cmd_t    cmd_in;
    rob_pkg::slv_cmd_t    cmd_head;
    rob_pkg::rd_payload_t rd_enq_data;
    rob_pkg::rd_payload_t rd_out_data;
    rob_pkg::wr_payload_t wr_enq_data;
    rob_pkg::wr_payload_t wr_out_data;
    logic                 rd_out_valid;
    logic                 wr_out_valid;
    mem_bus_pkg::user_t   rd_out_meta;
    mem_bus_pkg::user_t   wr_out_meta;

    // ==========================================================
    // Request side
    // ==========================================================

    // Any full buffer or a full queue holds the master off
    assign waitrequest = !rd_not_full || !wr_not_full || !fifo_not_full;

    // Read wins if a master ever raises both strobes
    assign rd_alloc = req.read && !waitrequest;
    assign wr_alloc = req.write && !req.read && !waitrequest;

    // The tag is the slot just claimed in the matching buffer
    assign cmd_in = '{read:       req.read,
                      write:      req.write && !req.read,
                      address:    req.address,
                      writedata:  req.writedata,
                      byteenable: req.byteenable,
                      tag:        req.read ? rd_alloc_idx : wr_alloc_idx};

    cmd_fifo2 i_cmd_fifo (
        .mem_master (mem_master),
        .rst        (rst),
        .enq_en     (rd_alloc || wr_alloc),
        .enq_data   (cmd_in),
        .not_full   (fifo_not_full),
        .first      (cmd_head),
        .not_empty  (fifo_not_empty),
        .deq_en     (fifo_not_empty && !slv_waitrequest)
    );

    // Strobes toward the slave only count while the queue holds a command
    always_comb
    begin
        slv_cmd       = cmd_head;
        slv_cmd.read  = cmd_head.read && fifo_not_empty;
        slv_cmd.write = cmd_head.write && fifo_not_empty;
    end

    // ==========================================================
    // Response side
    // ==========================================================
    assign rd_enq_data = '{readdata: slv_rd_rsp.readdata, response: slv_rd_rsp.response};
    assign wr_enq_data = '{response: slv_wr_rsp.response};

    rob_buffer #(
        .T_PAYLOAD (rob_pkg::rd_payload_t)
    ) i_rd_rob (
        .mem_master (mem_master),
        .rst        (rst),
        .alloc_en   (rd_alloc),
        .alloc_meta (req.user),
        .not_full   (rd_not_full),
        .alloc_idx  (rd_alloc_idx),
        .enq_en     (slv_rd_rsp.valid),
        .enq_idx    (slv_rd_rsp.tag),
        .enq_data   (rd_enq_data),
        .out_valid  (rd_out_valid),
        .out_data   (rd_out_data),
        .out_meta   (rd_out_meta)
    );

    rob_buffer #(
        .T_PAYLOAD (rob_pkg::wr_payload_t)
    ) i_wr_rob (
        .mem_master (mem_master),
        .rst        (rst),
        .alloc_en   (wr_alloc),
        .alloc_meta (req.user),
        .not_full   (wr_not_full),
        .alloc_idx  (wr_alloc_idx),
        .enq_en     (slv_wr_rsp.valid),
        .enq_idx    (slv_wr_rsp.tag),
        .enq_data   (wr_enq_data),
        .out_valid  (wr_out_valid),
        .out_data   (wr_out_data),
        .out_meta   (wr_out_meta)
    );

    // Sorted results go back with the user value restored
    assign rd_rsp = '{valid:    rd_out_valid,
                      readdata: rd_out_data.readdata,
                      response: rd_out_data.response,
                      user:     rd_out_meta};

    assign wr_rsp = '{valid:    wr_out_valid,
                      response: wr_out_data.response,
                      user:     wr_out_meta};

endmodule

// File: hw/mem_rob_top.sv
// Top level that puts the reorder bridge in front of the out-of-order memory model
`timescale 1ns/100ps

module mem_rob_top (
    input  logic                     mem_master,
    input  logic                     rst,
    input  mem_bus_pkg::mem_req_t    req,
    output logic                     waitrequest,
    output mem_bus_pkg::mem_rd_rsp_t rd_rsp,
    output mem_bus_pkg::mem_wr_rsp_t wr_rsp
);

    // Slave side between the bridge and the memory model
    rob_pkg::slv_cmd_t    slv_cmd;
    logic                 slv_waitrequest;
    rob_pkg::slv_rd_rsp_t slv_rd_rsp;
    rob_pkg::slv_wr_rsp_t slv_wr_rsp;

    mem_rob_bridge i_mem_rob_bridge (
        .mem_master      (mem_master),
        .rst             (rst),
        .req             (req),
        .waitrequest     (waitrequest),
        .rd_rsp          (rd_rsp),
        .wr_rsp          (wr_rsp),
        .slv_cmd         (slv_cmd),
        .slv_waitrequest (slv_waitrequest),
        .slv_rd_rsp      (slv_rd_rsp),
        .slv_wr_rsp      (slv_wr_rsp)
    );

    ooo_mem_model i_ooo_mem_model (
        .mem_master  (mem_master),
        .rst         (rst),
        .cmd         (slv_cmd),
        .waitrequest (slv_waitrequest),
        .rd_rsp      (slv_rd_rsp),
        .wr_rsp      (slv_wr_rsp)
    );

endmodule

// File: bench/mem_rob_tb.sv
// Self-checking testbench for the reorder bridge, run as the simulation top with the file list
`timescale 1ns/100ps
`include "mem_rob_config.svh"

module mem_rob_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int MEM_WORDS   = `MEM_ROB_MEM_WORDS;
    localparam int ENTRIES     = `MEM_ROB_ENTRIES;
    localparam int BE_W        = mem_bus_pkg::BE_WIDTH;
    localparam int N_DIRECTED  = 8;
    localparam int N_BURST     = 20;
    localparam int N_RANDOM    = 200;
    localparam int N_REQUESTS  = N_DIRECTED + N_BURST + N_RANDOM;
    localparam int WATCHDOG_NS = (N_REQUESTS * 40 + 100) * CLK_PERIOD;

    // What the master should see for one accepted request
    typedef struct packed {
        mem_bus_pkg::data_t data;
        mem_bus_pkg::resp_t resp;
        mem_bus_pkg::user_t user;
    } exp_rsp_t;

    logic                     mem_master;
    logic                     rst;
    mem_bus_pkg::mem_req_t    req;
    logic                     waitrequest;
    mem_bus_pkg::mem_rd_rsp_t rd_rsp;
    mem_bus_pkg::mem_wr_rsp_t wr_rsp;

    mem_bus_pkg::data_t ref_mem [MEM_WORDS];
    exp_rsp_t           exp_rd_q [$];
    exp_rsp_t           exp_wr_q [$];
    exp_rsp_t           rd_exp;
    exp_rsp_t           wr_exp;
    int                 error_count;
    int                 rd_accepted;
    int                 wr_accepted;
    int                 rd_responses;
    int                 wr_responses;

    mem_rob_top i_mem_rob_top (
        .mem_master  (mem_master),
        .rst         (rst),
        .req         (req),
        .waitrequest (waitrequest),
        .rd_rsp      (rd_rsp),
        .wr_rsp      (wr_rsp)
    );

    initial
    begin
        mem_master = 1'b0;
        forever #(CLK_PERIOD / 2) mem_master = ~mem_master;
    end

    // ============================================================
    // Checking helpers and request driver
    // ============================================================
    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        begin
            assert (actual === expected)
            else
            begin
                $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                         $time, name, expected, actual);
                error_count++;
            end
        end
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic issue_request(
        input logic               is_write,
        input mem_bus_pkg::addr_t addr,
        input mem_bus_pkg::data_t wdata,
        input mem_bus_pkg::be_t   be,
        input mem_bus_pkg::user_t user
    );
        exp_rsp_t exp;
        logic     in_range;
        begin
            req.read       = !is_write;
            req.write      = is_write;
            req.address    = addr;
            req.writedata  = wdata;
            req.byteenable = be;
            req.user       = user;
            // waitrequest follows only registered full flags, so it is settled here
            while (waitrequest)
                @(negedge mem_master);
            in_range = (int'(addr) < MEM_WORDS);
            exp.user = user;
            exp.resp = in_range ? mem_bus_pkg::resp_okay : mem_bus_pkg::resp_slverr;
            exp.data = '0;
            if (is_write)
            begin
                if (in_range)
                    for (int b = 0; b < BE_W; b++)
                        if (be[b])
                            ref_mem[addr][8*b +: 8] = wdata[8*b +: 8];
                exp_wr_q.push_back(exp);
                wr_accepted++;
            end
            else
            begin
                if (in_range)
                    exp.data = ref_mem[addr];
                exp_rd_q.push_back(exp);
                rd_accepted++;
            end
            @(negedge mem_master);
            req.read  = 1'b0;
            req.write = 1'b0;
        end
    endtask

    task automatic expect_idle_outputs();
        begin
            repeat (3)
            begin
                @(negedge mem_master);
                check_field("waitrequest", 32'd0, 32'(waitrequest));
                check_field("rd_rsp.valid", 32'd0, 32'(rd_rsp.valid));
                check_field("wr_rsp.valid", 32'd0, 32'(wr_rsp.valid));
            end
        end
    endtask

    // ============================================================
    // Stimulus sequences
    // ============================================================
    task automatic send_directed();
        begin
            issue_request(1'b1, 8'd3, 32'hcafe_f00d, 4'hf, 4'h1);
            issue_request(1'b0, 8'd3, '0, 4'hf, 4'h2);
            // Never written, so it reads as zero
            issue_request(1'b0, 8'd5, '0, 4'hf, 4'h3);
            issue_request(1'b1, 8'd3, 32'h1234_5678, 4'b0101, 4'h4);
            issue_request(1'b0, 8'd3, '0, 4'hf, 4'h5);
            // Beyond the implemented words, and its low bits alias word 3
            issue_request(1'b1, 8'd131, 32'hdead_beef, 4'hf, 4'h6);
            issue_request(1'b0, 8'd131, '0, 4'hf, 4'h7);
            issue_request(1'b0, 8'd3, '0, 4'hf, 4'h8);
        end
    endtask

    task automatic read_burst();
        begin
            for (int i = 0; i < N_BURST; i++)
                issue_request(1'b0, mem_bus_pkg::addr_t'(i % 16), '0, 4'hf,
                              mem_bus_pkg::user_t'(i));
        end
    endtask

    task automatic random_traffic();
        logic               is_write;
        mem_bus_pkg::addr_t addr;
        begin
            for (int i = 0; i < N_RANDOM; i++)
            begin
                is_write = ($urandom_range(0, 9) < 5);
                // Mostly a small address window so reads hit earlier writes
                if ($urandom_range(0, 9) == 0)
                    addr = mem_bus_pkg::addr_t'(MEM_WORDS + $urandom_range(0, 127));
                else
                    addr = mem_bus_pkg::addr_t'($urandom_range(0, 31));
                issue_request(is_write, addr, $urandom(), mem_bus_pkg::be_t'($urandom()),
                              mem_bus_pkg::user_t'($urandom()));
                if ($urandom_range(0, 7) == 0)
                    @(negedge mem_master);
            end
        end
    endtask

    // ============================================================
    // Response monitor
    // ============================================================
    always @(negedge mem_master)
    begin
        if (!rst && rd_rsp.valid)
        begin
            rd_responses++;
            assert (exp_rd_q.size() != 0)
            else
            begin
                $display("Read response at %0t ns arrived with no read outstanding", $time);
                error_count++;
            end
            if (exp_rd_q.size() != 0)
            begin
                rd_exp = exp_rd_q.pop_front();
                check_field("rd_rsp.readdata", rd_exp.data, rd_rsp.readdata);
                check_field("rd_rsp.response", 32'(rd_exp.resp), 32'(rd_rsp.response));
                check_field("rd_rsp.user", 32'(rd_exp.user), 32'(rd_rsp.user));
            end
        end
        if (!rst && wr_rsp.valid)
        begin
            wr_responses++;
            assert (exp_wr_q.size() != 0)
            else
            begin
                $display("Write response at %0t ns arrived with no write outstanding", $time);
                error_count++;
            end
            if (exp_wr_q.size() != 0)
            begin
                wr_exp = exp_wr_q.pop_front();
                check_field("wr_rsp.response", 32'(wr_exp.resp), 32'(wr_rsp.response));
                check_field("wr_rsp.user", 32'(wr_exp.user), 32'(wr_rsp.user));
            end
        end
        // Reads in flight are bounded by the depth of the read buffer
        assert (rd_accepted - rd_responses <= ENTRIES)
        else
        begin
            $display("Too many reads outstanding at %0t ns: %0d", $time,
                     rd_accepted - rd_responses);
            error_count++;
        end
    end

    // Stops a run where the DUT no longer answers
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns: responses stopped arriving", $time);
        $display("Run aborted with %0d errors", error_count);
        $display("** FAIL **");
        $finish;
    end

    // ============================================================
    // Main sequence
    // ============================================================
    initial
    begin
        void'($urandom(32'hdb86_d35c));
        rst          = 1'b1;
        req          = '0;
        error_count  = 0;
        rd_accepted  = 0;
        wr_accepted  = 0;
        rd_responses = 0;
        wr_responses = 0;
        for (int w = 0; w < MEM_WORDS; w++)
            ref_mem[w] = '0;

        // Three rising edges in reset, then release on a falling edge
        repeat (3) @(posedge mem_master);
        @(negedge mem_master);
        rst = 1'b0;

        expect_idle_outputs();
        send_directed();
        read_burst();
        random_traffic();

        // Drain every outstanding response
        while (exp_rd_q.size() != 0 || exp_wr_q.size() != 0)
            @(negedge mem_master);
        repeat (10) @(negedge mem_master);

        assert (rd_responses == rd_accepted && wr_responses == wr_accepted)
        else
        begin
            $display("Response count does not match accepted requests");
            error_count++;
        end

        $display("Run complete: %0d errors, %0d reads, %0d writes",
                 error_count, rd_responses, wr_responses);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: mem_rob.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/rob_pkg.sv
hw/rob_buffer.sv
hw/cmd_fifo2.sv
hw/ooo_mem_model.sv
hw/mem_rob_bridge.sv
hw/mem_rob_top.sv
bench/mem_rob_tb.sv

// File: Bender.yml
package:
  name: mem_rob

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_bus_pkg.sv
      - hw/rob_pkg.sv
      - hw/rob_buffer.sv
      - hw/cmd_fifo2.sv
      - hw/ooo_mem_model.sv
      - hw/mem_rob_bridge.sv
      - hw/mem_rob_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/mem_rob_tb.sv
